//--- design/banked_mem_pkg.sv
/* Sizes are fixed here, so no module takes parameters.
   A wide port spans NarrowPerWide neighbouring banks at one shared row. */

package banked_mem_pkg;

    // ------------------------------------------------------------
    // Sizes
    // ------------------------------------------------------------
    localparam int unsigned NumNarrowBanks  = 8;
    localparam int unsigned NarrowPerWide   = 4;
    localparam int unsigned NumWideBanks    = 2;
    localparam int unsigned NarrowDataWidth = 32;
    localparam int unsigned WideDataWidth   = 128;
    localparam int unsigned BankDepth       = 64;
    localparam int unsigned AddrWidth       = 6;

    // ------------------------------------------------------------
    // Encodings
    // ------------------------------------------------------------
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

    // Which side wins this cycle
    typedef enum logic {
        PRIO_NARROW = 1'b0,
        PRIO_WIDE   = 1'b1
    } arb_prio_e;

    // Owner of one bank access, also the response tag
    typedef enum logic {
        SRC_NARROW = 1'b0,
        SRC_WIDE   = 1'b1
    } bank_src_e;

    // ------------------------------------------------------------
    // Request and response structs
    // ------------------------------------------------------------
    typedef struct packed {
        logic                         q_valid;
        mem_op_e                      q_op;
        logic [AddrWidth-1:0]         q_addr;
        logic [NarrowDataWidth-1:0]   q_wdata;
        logic [NarrowDataWidth/8-1:0] q_strb;
    } mem_narrow_req_t;

    typedef struct packed {
        logic                       q_ready;
        logic                       p_valid;
        logic [NarrowDataWidth-1:0] p_rdata;
    } mem_narrow_rsp_t;

    typedef struct packed {
        logic                       q_valid;
        mem_op_e                    q_op;
        logic [AddrWidth-1:0]       q_addr;
        logic [WideDataWidth-1:0]   q_wdata;
        logic [WideDataWidth/8-1:0] q_strb;
    } mem_wide_req_t;

    typedef struct packed {
        logic                     q_ready;
        logic                     p_valid;
        logic [WideDataWidth-1:0] p_rdata;
    } mem_wide_rsp_t;

    // What a single bank sees after steering
    typedef struct packed {
        logic                         en;
        logic                         we;
        logic [AddrWidth-1:0]         addr;
        logic [NarrowDataWidth-1:0]   wdata;
        logic [NarrowDataWidth/8-1:0] be;
        bank_src_e                    src;
    } bank_req_t;

endpackage

//--- design/wide_narrow_arbiter.sv
/* Drives only q_ready. Readies are combinational from all q_valid inputs
   and a priority bit that flips every cycle, starting narrow after reset. */

`timescale 1ns/1ps

module wide_narrow_arbiter (
    input  logic clk_i,
    input  logic rst_ni,

    // Narrow side with one port per bank
    input  banked_mem_pkg::mem_narrow_req_t [banked_mem_pkg::NumNarrowBanks-1:0]
                                                    mem_narrow_req_i,
    // Wide side with one port per group of banks
    input  banked_mem_pkg::mem_wide_req_t   [banked_mem_pkg::NumWideBanks-1:0]
                                                    mem_wide_req_i,

    output logic [banked_mem_pkg::NumNarrowBanks-1:0] narrow_ready_o,
    output logic [banked_mem_pkg::NumWideBanks-1:0]   wide_ready_o
);

    import banked_mem_pkg::*;

    arb_prio_e                 prio_q;
    logic [NumNarrowBanks-1:0] narrow_valid;
    logic [NumNarrowBanks-1:0] wide_valid_split;
    logic [NumWideBanks-1:0]   narrow_valid_grp;
    logic [NumNarrowBanks-1:0] narrow_acc;
    logic [NumNarrowBanks-1:0] wide_acc_split;

    // Priority flips on every edge so neither side starves
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_q <= PRIO_NARROW;
        end else begin
            prio_q <= (prio_q == PRIO_NARROW) ? PRIO_WIDE : PRIO_NARROW;
        end
    end

    // ------------------------------------------------------------
    // Valid fan-out and fan-in per bank and per group
    // ------------------------------------------------------------
    for (genvar i = 0; i < NumNarrowBanks; i++) begin : g_bank
        assign narrow_valid[i]     = mem_narrow_req_i[i].q_valid;
        // Each bank sees the valid of the wide port covering it
        assign wide_valid_split[i] = mem_wide_req_i[i / NarrowPerWide].q_valid;
        assign narrow_acc[i]       = narrow_valid[i] & narrow_ready_o[i];
        assign wide_acc_split[i]   = wide_valid_split[i] & wide_ready_o[i / NarrowPerWide];
    end

    // Any narrow request inside a group blocks its wide port
    for (genvar g = 0; g < NumWideBanks; g++) begin : g_group
        assign narrow_valid_grp[g] = |narrow_valid[g*NarrowPerWide +: NarrowPerWide];
    end

    // ------------------------------------------------------------
    // Grant rule
    // ------------------------------------------------------------
    always_comb begin
        if (prio_q == PRIO_NARROW) begin
            // Narrow side always passes and wide only on an idle group
            narrow_ready_o = '1;
            wide_ready_o   = ~narrow_valid_grp;
        end else begin
            // Wide side always passes and narrow only if its group's wide port is idle
            wide_ready_o   = '1;
            narrow_ready_o = ~wide_valid_split;
        end
    end

    // No bank is handed to both sides on the same edge
    a_no_bank_overlap: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (narrow_acc & wide_acc_split) == '0
    ) else $error("Narrow and wide accepted on the same bank");

endmodule

//--- design/bank_port_mux.sv
/* Picks the accepted side for one bank, never both. slice_i is the lane
   of this bank inside its wide group and must be tied to a constant. */

`timescale 1ns/1ps

module bank_port_mux (
    input  banked_mem_pkg::mem_narrow_req_t narrow_req_i,
    input  logic                            narrow_ready_i,
    input  banked_mem_pkg::mem_wide_req_t   wide_req_i,
    input  logic                            wide_ready_i,
    // Lane index of this bank within the group
    input  logic [1:0]                      slice_i,
    output banked_mem_pkg::bank_req_t       bank_req_o
);

    import banked_mem_pkg::*;

    localparam int unsigned StrbWidth = NarrowDataWidth / 8;

    logic narrow_acc;
    logic wide_acc;

    // Acceptance is valid and ready seen together
    assign narrow_acc = narrow_req_i.q_valid & narrow_ready_i;
    assign wide_acc   = wide_req_i.q_valid & wide_ready_i;

    // ------------------------------------------------------------
    // Steering
    // ------------------------------------------------------------
    always_comb begin
        // Idle bank by default
        bank_req_o     = '0;
        bank_req_o.src = SRC_NARROW;

        if (wide_acc) begin
            bank_req_o.en    = 1'b1;
            bank_req_o.we    = (wide_req_i.q_op == MEM_WRITE);
            bank_req_o.addr  = wide_req_i.q_addr;
            // Only this bank's 32-bit lane and its strobes
            bank_req_o.wdata = wide_req_i.q_wdata[slice_i*NarrowDataWidth +: NarrowDataWidth];
            bank_req_o.be    = wide_req_i.q_strb[slice_i*StrbWidth +: StrbWidth];
            bank_req_o.src   = SRC_WIDE;
        end else if (narrow_acc) begin
            bank_req_o.en    = 1'b1;
            bank_req_o.we    = (narrow_req_i.q_op == MEM_WRITE);
            bank_req_o.addr  = narrow_req_i.q_addr;
            bank_req_o.wdata = narrow_req_i.q_wdata;
            bank_req_o.be    = narrow_req_i.q_strb;
            bank_req_o.src   = SRC_NARROW;
        end
    end

    // The arbiter must never let both sides through here
    always_comb begin
        a_single_side: assert final (!(narrow_acc && wide_acc))
            else $error("Bank accepted narrow and wide together");
    end

endmodule

//--- design/mem_bank.sv
/* Single-port bank, one-cycle read latency. Storage has no reset, so
   unwritten rows read as X. A read leaves rdata_o holding until the next read. */

`timescale 1ns/1ps

module mem_bank (
    input  logic                                      clk_i,
    input  logic                                      rst_ni,
    input  banked_mem_pkg::bank_req_t                 bank_req_i,
    output logic [banked_mem_pkg::NarrowDataWidth-1:0] rdata_o
);

    import banked_mem_pkg::*;

    logic [NarrowDataWidth-1:0] mem_q [BankDepth];

    // ------------------------------------------------------------
    // Byte-masked write
    // ------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (bank_req_i.en && bank_req_i.we) begin
            for (int b = 0; b < NarrowDataWidth / 8; b++) begin
                if (bank_req_i.be[b]) begin
                    mem_q[bank_req_i.addr][b*8 +: 8] <= bank_req_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    // Registered read, old contents on the accepting edge
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_o <= '0;
        end else if (bank_req_i.en && !bank_req_i.we) begin
            rdata_o <= mem_q[bank_req_i.addr];
        end
    end

endmodule

//--- design/rsp_router.sv
/* Tags each bank read with its source and returns it one cycle later.
   There is no back-pressure, so p_valid lasts exactly one cycle. */

`timescale 1ns/1ps

module rsp_router (
    input  logic clk_i,
    input  logic rst_ni,

    input  banked_mem_pkg::bank_req_t [banked_mem_pkg::NumNarrowBanks-1:0] bank_req_i,
    input  logic [banked_mem_pkg::NumNarrowBanks-1:0][banked_mem_pkg::NarrowDataWidth-1:0]
                                       bank_rdata_i,

    output logic [banked_mem_pkg::NumNarrowBanks-1:0] narrow_pvalid_o,
    output logic [banked_mem_pkg::NumNarrowBanks-1:0][banked_mem_pkg::NarrowDataWidth-1:0]
                                       narrow_rdata_o,
    output logic [banked_mem_pkg::NumWideBanks-1:0]   wide_pvalid_o,
    output logic [banked_mem_pkg::NumWideBanks-1:0][banked_mem_pkg::WideDataWidth-1:0]
                                       wide_rdata_o
);

    import banked_mem_pkg::*;

    logic [NumNarrowBanks-1:0] rd_q;
    bank_src_e                 src_q [NumNarrowBanks];

    // Remember per bank whether last edge was a read, and for whom
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_q <= '0;
            for (int i = 0; i < NumNarrowBanks; i++) begin
                src_q[i] <= SRC_NARROW;
            end
        end else begin
            for (int i = 0; i < NumNarrowBanks; i++) begin
                rd_q[i]  <= bank_req_i[i].en & ~bank_req_i[i].we;
                src_q[i] <= bank_req_i[i].src;
            end
        end
    end

    // ------------------------------------------------------------
    // Narrow responses
    // ------------------------------------------------------------
    for (genvar i = 0; i < NumNarrowBanks; i++) begin : g_narrow
        assign narrow_pvalid_o[i] = rd_q[i] & (src_q[i] == SRC_NARROW);
        assign narrow_rdata_o[i]  = bank_rdata_i[i];
    end

    // ------------------------------------------------------------
    // Wide responses
    // ------------------------------------------------------------
    for (genvar g = 0; g < NumWideBanks; g++) begin : g_wide
        localparam int unsigned Lane0 = g * NarrowPerWide;

        // Lane 0 speaks for the whole group
        assign wide_pvalid_o[g] = rd_q[Lane0] & (src_q[Lane0] == SRC_WIDE);
        // Bank 0 of the group lands in the low bits
        assign wide_rdata_o[g]  = bank_rdata_i[Lane0 +: NarrowPerWide];

        for (genvar l = 1; l < NarrowPerWide; l++) begin : g_lane
            // A wide read must have hit every lane of the group
            a_lane_tags_agree: assert property (
                @(posedge clk_i) disable iff (!rst_ni)
                wide_pvalid_o[g] |-> rd_q[Lane0+l] && (src_q[Lane0+l] == SRC_WIDE)
            ) else $error("Wide read lane tags disagree in group %0d", g);
        end
    end

endmodule

//--- design/banked_mem_top.sv
/* Eight narrow ports each own a bank, two wide ports span four banks each.
   Only reads return p_valid; writes complete silently on acceptance. */

`timescale 1ns/1ps

module banked_mem_top (
    input  logic clk_i,
    input  logic rst_ni,

    input  banked_mem_pkg::mem_narrow_req_t [banked_mem_pkg::NumNarrowBanks-1:0]
                                                    mem_narrow_req_i,
    output banked_mem_pkg::mem_narrow_rsp_t [banked_mem_pkg::NumNarrowBanks-1:0]
                                                    mem_narrow_rsp_o,
    input  banked_mem_pkg::mem_wide_req_t   [banked_mem_pkg::NumWideBanks-1:0]
                                                    mem_wide_req_i,
    output banked_mem_pkg::mem_wide_rsp_t   [banked_mem_pkg::NumWideBanks-1:0]
                                                    mem_wide_rsp_o
);

    import banked_mem_pkg::*;

    logic [NumNarrowBanks-1:0]                      narrow_ready;
    logic [NumWideBanks-1:0]                        wide_ready;
    bank_req_t [NumNarrowBanks-1:0]                 bank_req;
    logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0] bank_rdata;
    logic [NumNarrowBanks-1:0]                      narrow_pvalid;
    logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0] narrow_rdata;
    logic [NumWideBanks-1:0]                        wide_pvalid;
    logic [NumWideBanks-1:0][WideDataWidth-1:0]     wide_rdata;

    wide_narrow_arbiter i_arbiter (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .mem_narrow_req_i (mem_narrow_req_i),
        .mem_wide_req_i   (mem_wide_req_i),
        .narrow_ready_o   (narrow_ready),
        .wide_ready_o     (wide_ready)
    );

    // ------------------------------------------------------------
    // Per-bank steering and storage
    // ------------------------------------------------------------
    for (genvar i = 0; i < NumNarrowBanks; i++) begin : g_bank
        bank_port_mux i_mux (
            .narrow_req_i   (mem_narrow_req_i[i]),
            .narrow_ready_i (narrow_ready[i]),
            .wide_req_i     (mem_wide_req_i[i / NarrowPerWide]),
            .wide_ready_i   (wide_ready[i / NarrowPerWide]),
            .slice_i        (2'(i % NarrowPerWide)),
            .bank_req_o     (bank_req[i])
        );

        mem_bank i_bank (
            .clk_i      (clk_i),
            .rst_ni     (rst_ni),
            .bank_req_i (bank_req[i]),
            .rdata_o    (bank_rdata[i])
        );

        assign mem_narrow_rsp_o[i] = '{q_ready: narrow_ready[i], p_valid: narrow_pvalid[i],
                                       p_rdata: narrow_rdata[i]};
    end

    rsp_router i_router (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .bank_req_i      (bank_req),
        .bank_rdata_i    (bank_rdata),
        .narrow_pvalid_o (narrow_pvalid),
        .narrow_rdata_o  (narrow_rdata),
        .wide_pvalid_o   (wide_pvalid),
        .wide_rdata_o    (wide_rdata)
    );

    // Wide responses assembled from arbiter and router fields
    for (genvar g = 0; g < NumWideBanks; g++) begin : g_wide_rsp
        assign mem_wide_rsp_o[g] = '{q_ready: wide_ready[g], p_valid: wide_pvalid[g],
                                     p_rdata: wide_rdata[g]};
    end

endmodule

//--- verification/banked_mem_checker.sv
/* Watches every DUT port and predicts readies and read data.
   Bytes never written are masked out of data compares, since banks have no reset. */

`timescale 1ns/1ps

module banked_mem_checker (
    input  logic clk_i,
    input  logic rst_ni,
    input  banked_mem_pkg::mem_narrow_req_t [banked_mem_pkg::NumNarrowBanks-1:0] narrow_req_i,
    input  banked_mem_pkg::mem_narrow_rsp_t [banked_mem_pkg::NumNarrowBanks-1:0] narrow_rsp_i,
    input  banked_mem_pkg::mem_wide_req_t   [banked_mem_pkg::NumWideBanks-1:0]   wide_req_i,
    input  banked_mem_pkg::mem_wide_rsp_t   [banked_mem_pkg::NumWideBanks-1:0]   wide_rsp_i,
    output int                                                                   err_cnt_o
);

    import banked_mem_pkg::*;

    localparam int unsigned NumPorts = NumWideBanks + NumNarrowBanks;
    localparam int unsigned Nw       = NarrowDataWidth;

    // Memory model plus a mask of bytes holding known data
    logic [Nw-1:0]              mem_m   [NumNarrowBanks][BankDepth];
    logic [Nw-1:0]              known_m [NumNarrowBanks][BankDepth];
    // Expected reads, stored as {mask, data}
    logic [2*Nw-1:0]            narrow_exp_q [NumNarrowBanks][$];
    logic [2*WideDataWidth-1:0] wide_exp_q   [NumWideBanks][$];
    // Priority model, narrow on the first edge after reset
    logic                       wide_first;

    // Grant rule, readies packed as {wide, narrow}
    function automatic logic [NumPorts-1:0] expected_ready(
        input logic [NumNarrowBanks-1:0] nvalid,
        input logic [NumWideBanks-1:0]   wvalid,
        input logic                      wide_turn
    );
        logic [NumNarrowBanks-1:0] nrdy;
        logic [NumWideBanks-1:0]   wrdy;
        nrdy = '1;
        wrdy = '1;
        for (int i = 0; i < NumNarrowBanks; i++) begin
            if (wide_turn && wvalid[i / NarrowPerWide]) nrdy[i] = 1'b0;
            if (!wide_turn && nvalid[i]) wrdy[i / NarrowPerWide] = 1'b0;
        end
        return {wrdy, nrdy};
    endfunction

    task automatic flag_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        err_cnt_o++;
    endtask

    task automatic write_bytes(input int bank, input logic [AddrWidth-1:0] row,
                               input logic [Nw-1:0] data, input logic [Nw/8-1:0] strb);
        for (int b = 0; b < Nw / 8; b++) begin
            if (strb[b]) begin
                mem_m[bank][row][b*8 +: 8]   = data[b*8 +: 8];
                known_m[bank][row][b*8 +: 8] = 8'hFF;
            end
        end
    endtask

    // ------------------------------------------------------------
    // Per-edge compare, all values sampled before the edge
    // ------------------------------------------------------------
    always @(posedge clk_i or negedge rst_ni) begin
        logic [NumNarrowBanks-1:0]  nvalid;
        logic [NumNarrowBanks-1:0]  nrdy;
        logic [NumWideBanks-1:0]    wvalid;
        logic [NumWideBanks-1:0]    wrdy;
        logic [NumPorts-1:0]        exp_rdy;
        logic [2*Nw-1:0]            nexp;
        logic [2*WideDataWidth-1:0] wexp;
        logic [AddrWidth-1:0]       a;
        if (!rst_ni) begin
            err_cnt_o  = 0;
            wide_first = 1'b0;
            for (int i = 0; i < NumNarrowBanks; i++) begin
                narrow_exp_q[i].delete();
                for (int r = 0; r < BankDepth; r++) begin
                    mem_m[i][r]   = '0;
                    known_m[i][r] = '0;
                end
            end
            for (int g = 0; g < NumWideBanks; g++) wide_exp_q[g].delete();
        end else begin
            for (int i = 0; i < NumNarrowBanks; i++) begin
                nvalid[i] = narrow_req_i[i].q_valid;
                nrdy[i]   = narrow_rsp_i[i].q_ready;
            end
            for (int g = 0; g < NumWideBanks; g++) begin
                wvalid[g] = wide_req_i[g].q_valid;
                wrdy[g]   = wide_rsp_i[g].q_ready;
            end
            exp_rdy = expected_ready(nvalid, wvalid, wide_first);
            if ({wrdy, nrdy} !== exp_rdy)
                flag_error($sformatf("q_ready %b, expected %b", {wrdy, nrdy}, exp_rdy));

            // Responses owed by reads of the previous edge
            for (int i = 0; i < NumNarrowBanks; i++) begin
                if (narrow_rsp_i[i].p_valid) begin
                    if (narrow_exp_q[i].size() == 0) begin
                        flag_error($sformatf("narrow port %0d p_valid without a read", i));
                    end else begin
                        nexp = narrow_exp_q[i].pop_front();
                        if ((narrow_rsp_i[i].p_rdata & nexp[2*Nw-1:Nw]) !==
                            (nexp[Nw-1:0] & nexp[2*Nw-1:Nw]))
                            flag_error($sformatf("narrow port %0d read %h, expected %h",
                                                 i, narrow_rsp_i[i].p_rdata, nexp[Nw-1:0]));
                    end
                end else if (narrow_exp_q[i].size() != 0) begin
                    flag_error($sformatf("narrow port %0d missed its p_valid", i));
                    narrow_exp_q[i].delete();
                end
            end
            for (int g = 0; g < NumWideBanks; g++) begin
                if (wide_rsp_i[g].p_valid) begin
                    if (wide_exp_q[g].size() == 0) begin
                        flag_error($sformatf("wide port %0d p_valid without a read", g));
                    end else begin
                        wexp = wide_exp_q[g].pop_front();
                        if ((wide_rsp_i[g].p_rdata & wexp[2*WideDataWidth-1:WideDataWidth]) !==
                            (wexp[WideDataWidth-1:0] & wexp[2*WideDataWidth-1:WideDataWidth]))
                            flag_error($sformatf("wide port %0d read %h, expected %h",
                                                 g, wide_rsp_i[g].p_rdata,
                                                 wexp[WideDataWidth-1:0]));
                    end
                end else if (wide_exp_q[g].size() != 0) begin
                    flag_error($sformatf("wide port %0d missed its p_valid", g));
                    wide_exp_q[g].delete();
                end
            end

            // Requests accepted on this edge
            for (int i = 0; i < NumNarrowBanks; i++) begin
                a = narrow_req_i[i].q_addr;
                if (nvalid[i] && exp_rdy[i]) begin
                    if (narrow_req_i[i].q_op == MEM_READ)
                        narrow_exp_q[i].push_back({known_m[i][a], mem_m[i][a]});
                    else
                        write_bytes(i, a, narrow_req_i[i].q_wdata, narrow_req_i[i].q_strb);
                end
            end
            for (int g = 0; g < NumWideBanks; g++) begin
                a = wide_req_i[g].q_addr;
                if (wvalid[g] && exp_rdy[NumNarrowBanks + g]) begin
                    for (int l = 0; l < NarrowPerWide; l++) begin
                        // Bank 0 of the group sits in the low bits
                        wexp[l*Nw +: Nw]                 = mem_m[g*NarrowPerWide + l][a];
                        wexp[WideDataWidth + l*Nw +: Nw] = known_m[g*NarrowPerWide + l][a];
                        if (wide_req_i[g].q_op == MEM_WRITE)
                            write_bytes(g*NarrowPerWide + l, a, wide_req_i[g].q_wdata[l*Nw +: Nw],
                                        wide_req_i[g].q_strb[l*(Nw/8) +: Nw/8]);
                    end
                    if (wide_req_i[g].q_op == MEM_READ) wide_exp_q[g].push_back(wexp);
                end
            end
            wide_first = !wide_first;
        end
    end

endmodule

//--- verification/banked_mem_tb.sv
/* Drives requests on falling edges and leaves all comparing to the checker.
   Every handshake wait is bounded by its own cycle limit. */

`timescale 1ns/1ps

module banked_mem_tb;

    import banked_mem_pkg::*;

    logic                                 clk_i;
    logic                                 rst_ni;
    mem_narrow_req_t [NumNarrowBanks-1:0] narrow_req;
    mem_narrow_rsp_t [NumNarrowBanks-1:0] narrow_rsp;
    mem_wide_req_t   [NumWideBanks-1:0]   wide_req;
    mem_wide_rsp_t   [NumWideBanks-1:0]   wide_rsp;
    int                                   err_cnt;
    int                                   wait_errs;
    int                                   last_errs;
    int                                   n_pass;
    int                                   n_fail;
    integer                               seed;

    banked_mem_top DUT (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .mem_narrow_req_i (narrow_req),
        .mem_narrow_rsp_o (narrow_rsp),
        .mem_wide_req_i   (wide_req),
        .mem_wide_rsp_o   (wide_rsp)
    );

    banked_mem_checker i_checker (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .narrow_req_i (narrow_req),
        .narrow_rsp_i (narrow_rsp),
        .wide_req_i   (wide_req),
        .wide_rsp_i   (wide_rsp),
        .err_cnt_o    (err_cnt)
    );

    // 40 ns period
    always #20 clk_i = ~clk_i;

    // ------------------------------------------------------------
    // Handshake tasks called and returning on a falling edge
    // ------------------------------------------------------------
    task automatic narrow_xfer(input int p, input mem_op_e op, input logic [AddrWidth-1:0] addr,
                               input logic [31:0] wdata, input logic [3:0] strb,
                               input int max_cycles);
        int   n;
        logic ok;
        narrow_req[p] = '{q_valid: 1'b1, q_op: op, q_addr: addr, q_wdata: wdata, q_strb: strb};
        n  = 0;
        ok = 1'b0;
        while (!ok && n < max_cycles) begin
            @(posedge clk_i);
            ok = narrow_rsp[p].q_ready;
            n++;
        end
        @(negedge clk_i);
        narrow_req[p] = '0;
        if (!ok) begin
            $display("Narrow port %0d was not accepted within %0d cycles", p, max_cycles);
            wait_errs++;
        end
    endtask

    task automatic wide_xfer(input int g, input mem_op_e op, input logic [AddrWidth-1:0] addr,
                             input logic [127:0] wdata, input logic [15:0] strb,
                             input int max_cycles);
        int   n;
        logic ok;
        wide_req[g] = '{q_valid: 1'b1, q_op: op, q_addr: addr, q_wdata: wdata, q_strb: strb};
        n  = 0;
        ok = 1'b0;
        while (!ok && n < max_cycles) begin
            @(posedge clk_i);
            ok = wide_rsp[g].q_ready;
            n++;
        end
        @(negedge clk_i);
        wide_req[g] = '0;
        if (!ok) begin
            $display("Wide port %0d was not accepted within %0d cycles", g, max_cycles);
            wait_errs++;
        end
    endtask

    // Few rows so that random reads mostly hit written data
    function automatic mem_narrow_req_t random_narrow();
        mem_narrow_req_t r;
        r.q_valid = (($random(seed) & 3) == 0);
        r.q_op    = (($random(seed) & 1) != 0) ? MEM_WRITE : MEM_READ;
        r.q_addr  = AddrWidth'($random(seed) & 7);
        r.q_wdata = $random(seed);
        r.q_strb  = 4'($random(seed));
        return r;
    endfunction

    function automatic mem_wide_req_t random_wide();
        mem_wide_req_t r;
        r.q_valid = (($random(seed) & 3) == 0);
        r.q_op    = (($random(seed) & 1) != 0) ? MEM_WRITE : MEM_READ;
        r.q_addr  = AddrWidth'($random(seed) & 7);
        r.q_wdata = {$random(seed), $random(seed), $random(seed), $random(seed)};
        r.q_strb  = 16'($random(seed));
        return r;
    endfunction

    // Mixed traffic where a stalled request is held until accepted
    task automatic random_traffic(input int cycles);
        logic [NumNarrowBanks-1:0] n_busy;
        logic [NumWideBanks-1:0]   w_busy;
        int                        n_age [NumNarrowBanks];
        int                        w_age [NumWideBanks];
        n_busy = '0;
        w_busy = '0;
        for (int i = 0; i < NumNarrowBanks; i++) begin
            n_age[i] = 0;
        end
        for (int g = 0; g < NumWideBanks; g++) begin
            w_age[g] = 0;
        end
        repeat (cycles) begin
            for (int i = 0; i < NumNarrowBanks; i++) begin
                if (!n_busy[i]) narrow_req[i] = random_narrow();
            end
            for (int g = 0; g < NumWideBanks; g++) begin
                if (!w_busy[g]) wide_req[g] = random_wide();
            end
            @(posedge clk_i);
            for (int i = 0; i < NumNarrowBanks; i++) begin
                n_busy[i] = narrow_req[i].q_valid & ~narrow_rsp[i].q_ready;
                n_age[i]  = n_busy[i] ? n_age[i] + 1 : 0;
                if (n_age[i] >= 2) begin
                    $display("Narrow port %0d still stalled after two cycles", i);
                    wait_errs++;
                    n_busy[i] = 1'b0;
                    n_age[i]  = 0;
                end
            end
            for (int g = 0; g < NumWideBanks; g++) begin
                w_busy[g] = wide_req[g].q_valid & ~wide_rsp[g].q_ready;
                w_age[g]  = w_busy[g] ? w_age[g] + 1 : 0;
                if (w_age[g] >= 2) begin
                    $display("Wide port %0d still stalled after two cycles", g);
                    wait_errs++;
                    w_busy[g] = 1'b0;
                    w_age[g]  = 0;
                end
            end
            @(negedge clk_i);
        end
        narrow_req = '0;
        wide_req   = '0;
    endtask

    task automatic close_test(input string name);
        int errs;
        errs      = err_cnt + wait_errs - last_errs;
        last_errs = err_cnt + wait_errs;
        if (errs == 0) begin
            n_pass++;
            $display("[%0t ns] %s: passed", $time, name);
        end else begin
            n_fail++;
            $display("[%0t ns] %s: %0d errors", $time, name, errs);
        end
    endtask

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin
        clk_i      = 1'b0;
        rst_ni     = 1'b0;
        narrow_req = '0;
        wide_req   = '0;
        seed       = 68784;
        wait_errs  = 0;
        last_errs  = 0;
        n_pass     = 0;
        n_fail     = 0;
        repeat (5) @(negedge clk_i);
        rst_ni = 1'b1;

        // Checker sees all readies high and no p_valid while idle
        repeat (4) @(negedge clk_i);
        close_test("idle after reset");

        // Partial strobes merge into earlier bytes
        narrow_xfer(2, MEM_WRITE, 6'd5, 32'h1122_3344, 4'hF, 2);
        narrow_xfer(2, MEM_WRITE, 6'd5, 32'hAABB_CCDD, 4'b0101, 2);
        narrow_xfer(2, MEM_READ, 6'd5, '0, '0, 2);
        narrow_xfer(6, MEM_WRITE, 6'd9, 32'h0BAD_F00D, 4'hF, 2);
        narrow_xfer(6, MEM_WRITE, 6'd9, 32'hCAFE_0000, 4'b1100, 2);
        narrow_xfer(6, MEM_READ, 6'd9, '0, '0, 2);
        repeat (2) @(negedge clk_i);
        close_test("narrow strobed writes");

        // Wide write read back per lane
        wide_xfer(1, MEM_WRITE, 6'd12, 128'h4444_4444_3333_3333_2222_2222_1111_1111, '1, 2);
        for (int l = 0; l < NarrowPerWide; l++) begin
            narrow_xfer(4 + l, MEM_READ, 6'd12, '0, '0, 2);
        end
        // Narrow writes read back as one wide word
        for (int l = 0; l < NarrowPerWide; l++) begin
            narrow_xfer(l, MEM_WRITE, 6'd20, 32'(l * 16 + 7), '1, 2);
        end
        wide_xfer(0, MEM_READ, 6'd20, '0, '0, 2);
        repeat (2) @(negedge clk_i);
        close_test("wide and narrow lanes");

        // Contention on one group with the phase shifted halfway
        for (int r = 0; r < 4; r++) begin
            if (r == 2) @(negedge clk_i);
            fork
                narrow_xfer((r % 2) * NarrowPerWide + r, MEM_WRITE, AddrWidth'(r), $random(seed),
                            '1, 2);
                wide_xfer(r % 2, MEM_READ, AddrWidth'(r), '0, '0, 2);
            join
        end
        repeat (2) @(negedge clk_i);
        close_test("narrow and wide contention");

        // Back-to-back reads across banks and groups
        narrow_xfer(2, MEM_READ, 6'd5, '0, '0, 2);
        wide_xfer(1, MEM_READ, 6'd12, '0, '0, 2);
        narrow_xfer(4, MEM_READ, 6'd12, '0, '0, 2);
        wide_xfer(0, MEM_READ, 6'd20, '0, '0, 2);
        narrow_xfer(0, MEM_READ, 6'd20, '0, '0, 2);
        repeat (2) @(negedge clk_i);
        close_test("consecutive reads");

        random_traffic(300);
        repeat (3) @(negedge clk_i);
        close_test("random traffic");

        $display("Tests passed: %0d, failed: %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- banked_mem_top.f
design/banked_mem_pkg.sv
design/wide_narrow_arbiter.sv
design/bank_port_mux.sv
design/mem_bank.sv
design/rsp_router.sv
design/banked_mem_top.sv
verification/banked_mem_checker.sv
verification/banked_mem_tb.sv

//--- Makefile
# Verilator build and run for the banked scratchpad testbench

TOOL     := verilator
FLAGS    := --binary --timing
TOP      := banked_mem_tb
FILELIST := banked_mem_top.f
BUILD    := obj_dir
LOG      := sim.log
PASS_MSG := Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

# Pass or fail is decided by the pass message in the log
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
